// ==== include/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// line geometry
`define DC_OFFSET_BITS 5
`define DC_INDEX_BITS 7

// whatever is left of a 32-bit address
`define DC_TAG_BITS (32 - `DC_OFFSET_BITS - `DC_INDEX_BITS)

`define DC_WORDS_PER_LINE 8    // also beats per burst
`define DC_WORD_SEL_BITS 3

`endif

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_BITS-1:0] tag_t;
    typedef logic [`DC_INDEX_BITS-1:0] index_t;
    typedef logic [`DC_WORD_SEL_BITS-1:0] word_sel_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [`DC_INDEX_BITS+`DC_WORD_SEL_BITS-1:0] ram_addr_t;   // {index, word}

    typedef enum logic [2:0] {
        ms_idle,
        ms_victim_read,
        ms_writeback,
        ms_refill,
        ms_done
    } miss_state_t;

    // store bytes over an existing word
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
        word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    // byte address, bursts are line aligned
    typedef logic [31:0] bus_addr_t;

    // one beat on either data channel
    typedef logic [31:0] bus_word_t;

endpackage

`default_nettype wire

// ==== verilog/way_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module way_ram #(
    parameter int WIDTH = 32,
    parameter int ADDR_BITS = 10
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] waddr,
    input  logic [WIDTH-1:0]     wdata,
    input  logic                 re,
    input  logic [ADDR_BITS-1:0] raddr,
    output logic [WIDTH-1:0]     rdata
);

    logic [WIDTH-1:0] mem [0:(1 << ADDR_BITS)-1];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // registered read, holds when re is low
    always_ff @(posedge clk) begin
        if (re)
            rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== verilog/set_state.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module set_state import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  index_t     index,
    output logic [1:0] valid,
    output logic [1:0] dirty,
    output logic       victim,
    input  logic       hit_upd,
    input  logic       hit_way,
    input  logic       hit_store,
    input  logic       fill_upd,
    input  logic       fill_way,
    input  logic       fill_dirty,
    input  index_t     upd_index,
    input  logic       clean_upd
);

    logic [1:0] valid_q [0:(1 << `DC_INDEX_BITS)-1];
    logic [1:0] dirty_q [0:(1 << `DC_INDEX_BITS)-1];
    logic       lru_q   [0:(1 << `DC_INDEX_BITS)-1];   // names the next victim

    assign valid  = valid_q[index];
    assign dirty  = dirty_q[index];
    assign victim = lru_q[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `DC_INDEX_BITS); i++) begin
                valid_q[i] <= 2'b00;
                dirty_q[i] <= 2'b00;
                lru_q[i]   <= 1'b0;
            end
        end else begin
            if (hit_upd) begin
                lru_q[upd_index] <= ~hit_way;
                if (hit_store)
                    dirty_q[upd_index][hit_way] <= 1'b1;
            end
            if (clean_upd)
                dirty_q[upd_index][fill_way] <= 1'b0;   // written back
            if (fill_upd) begin
                valid_q[upd_index][fill_way] <= 1'b1;
                dirty_q[upd_index][fill_way] <= fill_dirty;
                lru_q[upd_index] <= ~fill_way;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/miss_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module miss_controller import dcache_pkg::*, mem_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  index_t     miss_index,
    input  tag_t       miss_tag,
    input  word_sel_t  miss_word,
    input  logic       is_store,
    input  word_t      store_data,
    input  byte_en_t   store_strb,
    input  logic       victim_way,
    input  logic [1:0] victim_dirty,   // dirty bits of both ways in the set
    input  tag_t       victim_tag,
    input  word_t      victim_word,
    output ram_addr_t  data_raddr,
    output logic       data_re,
    output logic       fill_we,
    output ram_addr_t  fill_addr,
    output word_t      fill_word,
    output logic       tag_we,
    output logic       meta_fill,
    output logic       meta_clean,
    output word_t      resp_word,
    output logic       done,
    // memory side
    output bus_addr_t  araddr,
    output logic       arvalid,
    input  logic       arready,
    input  bus_word_t  rdata_mem,
    input  logic       rvalid,
    input  logic       rlast,
    output logic       rready,
    output bus_addr_t  awaddr,
    output logic       awvalid,
    input  logic       awready,
    output bus_word_t  wdata_mem,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid
);

    miss_state_t state;
    logic [`DC_WORD_SEL_BITS:0] rd_cnt;   // victim read, one more than a line
    word_sel_t beat;
    tag_t wb_tag;
    word_t line_buf [0:`DC_WORDS_PER_LINE-1];
    logic beat_ok;

    assign araddr = {miss_tag, miss_index, {`DC_OFFSET_BITS{1'b0}}};
    assign awaddr = {wb_tag, miss_index, {`DC_OFFSET_BITS{1'b0}}};
    assign wdata_mem = line_buf[beat];
    assign wlast = wvalid & (beat == word_sel_t'(`DC_WORDS_PER_LINE - 1));

    // victim read address runs one cycle ahead of the capture
    assign data_re = (state == ms_victim_read) & (rd_cnt < `DC_WORDS_PER_LINE);
    assign data_raddr = {miss_index, rd_cnt[`DC_WORD_SEL_BITS-1:0]};

    assign beat_ok = (state == ms_refill) & rvalid & rready;
    assign fill_we = beat_ok;
    assign fill_addr = {miss_index, beat};
    assign fill_word = (is_store && beat == miss_word) ?
                       merge_bytes(rdata_mem, store_data, store_strb) : rdata_mem;
    assign tag_we = beat_ok & rlast;
    assign meta_fill = beat_ok & rlast;
    assign meta_clean = (state == ms_writeback) & bvalid;
    assign done = (state == ms_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ms_idle;
            rd_cnt  <= '0;
            beat    <= '0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                ms_idle: begin
                    beat   <= '0;
                    rd_cnt <= '0;
                    if (start) begin
                        if (victim_dirty[victim_way]) begin
                            state <= ms_victim_read;
                        end else begin
                            state   <= ms_refill;
                            arvalid <= 1'b1;
                        end
                    end
                end
                ms_victim_read: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == `DC_WORDS_PER_LINE) begin
                        state   <= ms_writeback;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end
                end
                ms_writeback: begin
                    if (awvalid && awready)
                        awvalid <= 1'b0;
                    if (wvalid && wready) begin
                        if (wlast)
                            wvalid <= 1'b0;
                        else
                            beat <= beat + 1'b1;
                    end
                    if (bvalid) begin
                        state   <= ms_refill;
                        beat    <= '0;
                        arvalid <= 1'b1;
                    end
                end
                ms_refill: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (beat_ok) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            rready <= 1'b0;
                            state  <= ms_done;
                        end
                    end
                end
                default: state <= ms_idle;   // ms_done
            endcase
        end
    end

    // line buffer and captured words
    always_ff @(posedge clk) begin
        if (state == ms_idle && start)
            wb_tag <= victim_tag;
        if (state == ms_victim_read && rd_cnt != 0)
            line_buf[word_sel_t'(rd_cnt - 1'b1)] <= victim_word;
        if (beat_ok && beat == miss_word)
            resp_word <= fill_word;   // already merged on a store
    end

endmodule

`default_nettype wire

// ==== verilog/d_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module d_cache import dcache_pkg::*, mem_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // processor side
    input  logic      req,
    input  logic      wr,
    input  bus_addr_t addr,
    input  word_t     wdata,
    input  byte_en_t  wstrb,
    output logic      stall,
    output word_t     rdata,
    // memory side
    output bus_addr_t araddr,
    output logic      arvalid,
    input  logic      arready,
    input  bus_word_t rdata_mem,
    input  logic      rvalid,
    input  logic      rlast,
    output logic      rready,
    output bus_addr_t awaddr,
    output logic      awvalid,
    input  logic      awready,
    output bus_word_t wdata_mem,
    output logic      wlast,
    output logic      wvalid,
    input  logic      wready,
    input  logic      bvalid
);

    tag_t      in_tag, lk_tag;
    index_t    in_index, lk_index;
    word_sel_t in_word, lk_word;
    logic      lk_valid, lk_wr, miss_active, resp_ok;
    word_t     lk_wdata;
    byte_en_t  lk_strb;
    tag_t      tag_rd [2];
    word_t     data_rd [2];
    logic [1:0] valid, dirty, way_hit;
    logic      victim, hit_way, lk_hit, lk_miss, store_hit, hazard, accept, start;
    logic      data_re, fill_we, tag_we, meta_fill, meta_clean, done;
    ram_addr_t mc_raddr, fill_addr, data_raddr, data_waddr;
    word_t     fill_word, resp_word, data_wdata;

    assign in_tag   = addr[31 -: `DC_TAG_BITS];
    assign in_index = addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign in_word  = addr[2 +: `DC_WORD_SEL_BITS];

    assign way_hit[0] = valid[0] & (tag_rd[0] == lk_tag);
    assign way_hit[1] = valid[1] & (tag_rd[1] == lk_tag);
    assign hit_way = way_hit[1];

    // once a miss starts the request waits for the refill response
    assign lk_miss = lk_valid & ~resp_ok & (miss_active | ~|way_hit);
    assign lk_hit  = lk_valid & ~resp_ok & ~miss_active & |way_hit;
    assign store_hit = lk_hit & lk_wr;

    // any access to the word just stored would read the old RAM word
    assign hazard = store_hit & req & ({in_tag, in_index, in_word} == {lk_tag, lk_index, lk_word});
    assign stall  = lk_miss | hazard;
    assign accept = req & ~stall;
    assign start  = lk_miss & ~miss_active;

    assign data_raddr = data_re ? mc_raddr : {in_index, in_word};
    assign data_waddr = miss_active ? fill_addr : {lk_index, lk_word};
    assign data_wdata = miss_active ? fill_word : merge_bytes(data_rd[hit_way], lk_wdata, lk_strb);
    assign rdata = resp_ok ? resp_word : data_rd[hit_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            lk_valid    <= 1'b0;
            miss_active <= 1'b0;
            resp_ok     <= 1'b0;
        end else begin
            resp_ok <= done;
            if (start)
                miss_active <= 1'b1;
            else if (done)
                miss_active <= 1'b0;
            if (accept)
                lk_valid <= 1'b1;
            else if (!lk_miss)
                lk_valid <= 1'b0;
        end
    end

    // lookup stage payload
    always_ff @(posedge clk) begin
        if (accept) begin
            lk_tag   <= in_tag;
            lk_index <= in_index;
            lk_word  <= in_word;
            lk_wr    <= wr;
            lk_wdata <= wdata;
            lk_strb  <= wstrb;
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        way_ram #(.WIDTH(`DC_TAG_BITS), .ADDR_BITS(`DC_INDEX_BITS)) u_tag (
            .clk(clk), .we(tag_we & (victim == 1'(w))), .waddr(lk_index), .wdata(lk_tag),
            .re(accept), .raddr(in_index), .rdata(tag_rd[w])
        );
        way_ram #(.WIDTH(32), .ADDR_BITS(`DC_INDEX_BITS + `DC_WORD_SEL_BITS)) u_data (
            .clk(clk),
            .we((fill_we & (victim == 1'(w))) | (store_hit & (hit_way == 1'(w)))),
            .waddr(data_waddr), .wdata(data_wdata),
            .re(accept | data_re), .raddr(data_raddr), .rdata(data_rd[w])
        );
    end

    set_state u_set_state (
        .clk(clk), .rst(rst), .index(lk_index), .valid(valid), .dirty(dirty),
        .victim(victim), .hit_upd(lk_hit), .hit_way(hit_way), .hit_store(lk_wr),
        .fill_upd(meta_fill), .fill_way(victim), .fill_dirty(lk_wr),
        .upd_index(lk_index), .clean_upd(meta_clean)
    );

    miss_controller u_miss (
        .clk(clk), .rst(rst), .start(start), .miss_index(lk_index), .miss_tag(lk_tag),
        .miss_word(lk_word), .is_store(lk_wr), .store_data(lk_wdata), .store_strb(lk_strb),
        .victim_way(victim), .victim_dirty(dirty), .victim_tag(tag_rd[victim]),
        .victim_word(data_rd[victim]), .data_raddr(mc_raddr), .data_re(data_re),
        .fill_we(fill_we), .fill_addr(fill_addr), .fill_word(fill_word), .tag_we(tag_we),
        .meta_fill(meta_fill), .meta_clean(meta_clean), .resp_word(resp_word), .done(done),
        .araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata_mem(rdata_mem),
        .rvalid(rvalid), .rlast(rlast), .rready(rready), .awaddr(awaddr),
        .awvalid(awvalid), .awready(awready), .wdata_mem(wdata_mem), .wlast(wlast),
        .wvalid(wvalid), .wready(wready), .bvalid(bvalid)
    );

endmodule

`default_nettype wire

// ==== testbench/mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_model import mem_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  bus_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output bus_word_t rdata_mem,
    output logic      rvalid,
    output logic      rlast,
    input  logic      rready,
    input  bus_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  bus_word_t wdata_mem,
    input  logic      wlast,
    input  logic      wvalid,
    output logic      wready,
    output logic      bvalid
);

    bus_word_t mem [0:4095];
    bus_word_t wr_buf [0:7];
    int read_bursts;
    int rd_base, rd_beat, wr_base, wr_beat;
    logic rd_busy, aw_seen, w_seen;

    // ready or valid three times out of four
    function automatic logic mostly_ready();
        return ($urandom % 4) != 0;
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++)
            mem[i] = bus_word_t'(i) ^ 32'hA5A5_0000;
        read_bursts = 0;
        rdata_mem = '0;
        bvalid = 1'b0;
        rd_busy = 1'b0;
        aw_seen = 1'b0;
        w_seen = 1'b0;
        wr_beat = 0;
        forever begin
            // outputs change on the falling edge for the next rising edge
            arready = 1'b0;
            awready = 1'b0;
            wready  = 1'b0;
            rvalid  = 1'b0;
            rlast   = 1'b0;
            if (rst || bvalid) begin
                bvalid  = 1'b0;   // one-cycle response
                aw_seen = 1'b0;
                w_seen  = 1'b0;
                wr_beat = 0;
                if (rst)
                    rd_busy = 1'b0;
            end else if (aw_seen && w_seen && mostly_ready()) begin
                for (int i = 0; i < 8; i++)
                    mem[wr_base + i] = wr_buf[i];
                bvalid = 1'b1;
            end
            if (!rst && awvalid && !aw_seen) begin
                awready = mostly_ready();
                if (awready) begin
                    aw_seen = 1'b1;
                    wr_base = int'(awaddr[13:2]);
                end
            end
            if (!rst && wvalid && !w_seen) begin
                wready = mostly_ready();
                if (wready) begin
                    wr_buf[wr_beat % 8] = wdata_mem;
                    wr_beat++;
                    w_seen = wlast;
                end
            end
            if (!rst && arvalid && !rd_busy) begin
                arready = mostly_ready();
                if (arready) begin
                    rd_busy = 1'b1;
                    rd_base = int'(araddr[13:2]);
                    rd_beat = 0;
                    read_bursts++;
                end
            end else if (!rst && rd_busy) begin
                rvalid = mostly_ready();
                rdata_mem = mem[rd_base + rd_beat];
                rlast = rvalid && (rd_beat == 7);
                if (rvalid && rready) begin
                    rd_beat++;
                    rd_busy = (rd_beat != 8);
                end
            end
            @(negedge clk);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_d_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module tb_d_cache import dcache_pkg::*, mem_bus_pkg::*; ();

    localparam int max_requests = 600;
    localparam int worst_request_ns = 400;

    logic      clk, rst, req, wr, stall;
    bus_addr_t addr, araddr, awaddr;
    word_t     wdata, rdata;
    byte_en_t  wstrb;
    logic      arvalid, arready, rvalid, rlast, rready;
    logic      awvalid, awready, wlast, wvalid, wready, bvalid;
    bus_word_t rdata_mem, wdata_mem;

    word_t ref_mem [0:4095];
    logic  pend_valid;   // a load waits for its lookup result
    word_t pend_exp;
    int    last_wait;    // stall cycles seen by the latest request

    d_cache u_dut (.*);
    mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(max_requests * worst_request_ns);
        $display("Test failed");
        $fatal(1, "watchdog expired before the tests finished");
    end

    function automatic bus_addr_t make_addr(input int tag, input int set, input int word);
        return bus_addr_t'((tag << (`DC_OFFSET_BITS + `DC_INDEX_BITS)) |
                           (set << `DC_OFFSET_BITS) | (word << 2));
    endfunction

    function automatic int word_index(input bus_addr_t a);
        return int'(a[13:2]);
    endfunction

    function automatic word_t apply_strobe(input word_t old_w, input word_t new_w,
                                           input byte_en_t be);
        word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("Error: at %0t ns, %s expected %h, actual %h", $time, name, exp, got);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // stall is low, so an earlier load sits in lookup or in its response cycle
    task automatic check_previous_load();
        if (pend_valid)
            check_value("rdata", pend_exp, rdata);
        pend_valid = 1'b0;
    endtask

    task automatic send_request(input logic w, input bus_addr_t a, input word_t d,
                                input byte_en_t be);
        @(negedge clk);
        req = 1'b1;
        wr = w;
        addr = a;
        wdata = d;
        wstrb = be;
        last_wait = 0;
        #1;
        while (stall) begin
            @(negedge clk);
            #1;
            last_wait++;
        end
        check_previous_load();
    endtask

    task automatic drain_pipeline();
        @(negedge clk);
        req = 1'b0;
        #1;
        while (stall) begin
            @(negedge clk);
            #1;
        end
        check_previous_load();
    endtask

    task automatic load_word(input bus_addr_t a);
        send_request(1'b0, a, '0, '0);
        pend_valid = 1'b1;
        pend_exp = ref_mem[word_index(a)];
    endtask

    task automatic store_word(input bus_addr_t a, input word_t d, input byte_en_t be);
        send_request(1'b1, a, d, be);
        ref_mem[word_index(a)] = apply_strobe(ref_mem[word_index(a)], d, be);
    endtask

    task automatic refill_line_check();
        int bursts;
        bursts = u_mem.read_bursts;
        for (int w = 0; w < 8; w++)
            load_word(make_addr(1, 3, w));
        drain_pipeline();
        check_value("read_bursts", 32'(bursts + 1), u_mem.read_bursts);
    endtask

    task automatic store_load_hazard();
        store_word(make_addr(1, 3, 2), 32'hDEAD_BEEF, 4'b0101);
        load_word(make_addr(1, 3, 2));
        check_value("stall cycles", 1, last_wait);
        drain_pipeline();
    endtask

    task automatic store_miss_merge();
        store_word(make_addr(2, 5, 6), 32'h1234_5678, 4'b1100);
        load_word(make_addr(2, 5, 6));
        drain_pipeline();
    endtask

    task automatic dirty_writeback();
        store_word(make_addr(0, 9, 1), 32'hCAFE_0001, 4'b1111);
        store_word(make_addr(1, 9, 4), 32'hCAFE_0104, 4'b1111);
        load_word(make_addr(2, 9, 0));   // evicts tag 0
        drain_pipeline();
        check_value("u_mem.mem", ref_mem[word_index(make_addr(0, 9, 1))],
                    u_mem.mem[word_index(make_addr(0, 9, 1))]);
        load_word(make_addr(0, 9, 1));   // evicts tag 1
        drain_pipeline();
        check_value("u_mem.mem", ref_mem[word_index(make_addr(1, 9, 4))],
                    u_mem.mem[word_index(make_addr(1, 9, 4))]);
    endtask

    task automatic lru_victim();
        int bursts;
        load_word(make_addr(0, 12, 0));
        load_word(make_addr(1, 12, 0));
        load_word(make_addr(0, 12, 3));
        load_word(make_addr(2, 12, 0));   // B is the older one
        drain_pipeline();
        bursts = u_mem.read_bursts;
        load_word(make_addr(0, 12, 5));
        drain_pipeline();
        check_value("read_bursts", 32'(bursts), u_mem.read_bursts);
    endtask

    task automatic random_traffic();
        bus_addr_t a;
        for (int n = 0; n < 500; n++) begin
            a = make_addr(int'($urandom % 4), int'($urandom % 16), int'($urandom % 8));
            if ($urandom % 2)
                store_word(a, $urandom, byte_en_t'($urandom));
            else
                load_word(a);
        end
        drain_pipeline();
    endtask

    initial begin
        void'($urandom(32'h7e85_6c91));
        rst = 1'b1;
        req = 1'b0;
        wr = 1'b0;
        addr = '0;
        wdata = '0;
        wstrb = '0;
        pend_valid = 1'b0;
        pend_exp = '0;
        last_wait = 0;
        for (int i = 0; i < 4096; i++)
            ref_mem[i] = word_t'(i) ^ 32'hA5A5_0000;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        refill_line_check();
        store_load_hazard();
        store_miss_merge();
        dirty_writeback();
        lru_victim();
        random_traffic();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
verilog/dcache_pkg.sv
verilog/mem_bus_pkg.sv
verilog/way_ram.sv
verilog/set_state.sv
verilog/miss_controller.sv
verilog/d_cache.sv
testbench/mem_model.sv
testbench/tb_d_cache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the d_cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_d_cache -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_d_cache
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0
